//--- filelist.f
design/ooo_cb_pkg.sv
design/fu_writeback_lane.sv
design/completion_buffer.sv
design/retire_unit.sv
design/ooo_writeback_top.sv
dv/ooo_writeback_properties.sv
dv/tb_ooo_writeback.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the completion-side testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ooo_writeback -f filelist.f

status=0
output=$(./obj_dir/Vtb_ooo_writeback 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "Test OK" <<< "$output"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

//--- dv/tb_ooo_writeback.sv
// testbench for the completion side of the ooo core
// random dispatch and out-of-order completion checked against a queue model
// compare tasks, closing summary, watchdog

`timescale 1ns/1ns

module tb_ooo_writeback;

  localparam int NUM_LANES = 3;
  localparam int CB_DEPTH  = 8;
  localparam int IDX_W     = $clog2(CB_DEPTH);
  localparam int NUM_OPS   = 400;   // allocations over the run
  localparam int CLK_NS    = 20;
  localparam longint WATCHDOG_NS = longint'(NUM_OPS) * 40 * CLK_NS;

  typedef logic [ooo_cb_pkg::XLEN-1:0] word_t;

  // one outstanding instruction, program order
  typedef struct packed {
    logic [IDX_W-1:0]   idx;
    logic [4:0]         rd;
    logic               issued;  // result sent to a lane
    logic               exc;
    ooo_cb_pkg::cause_e cause;
    word_t              pc;
    word_t              word;    // expected rf_wdata
  } entry_t;

  logic CLK = 1'b0;
  logic nRST;
  logic alloc_valid;
  logic [4:0] alloc_rd;
  logic [NUM_LANES-1:0] fu_valid, fu_is_jump, fu_is_load, fu_is_store, fu_illegal;
  logic [NUM_LANES-1:0][IDX_W-1:0] fu_index;
  logic [NUM_LANES-1:0][ooo_cb_pkg::XLEN-1:0] fu_pc, fu_result, fu_addr;
  logic [IDX_W-1:0] alloc_index;
  logic cb_full, rf_wen, exc_valid;
  logic [4:0] rf_rd;
  word_t rf_wdata, exc_pc;
  ooo_cb_pkg::cause_e exc_cause;
  logic [31:0] retired_count;

  // stimulus for the next edge
  logic n_alloc;
  logic [4:0] n_rd;
  logic [NUM_LANES-1:0] n_valid, n_jump, n_load, n_store, n_illegal;
  logic [NUM_LANES-1:0][IDX_W-1:0] n_index;
  logic [NUM_LANES-1:0][ooo_cb_pkg::XLEN-1:0] n_pc, n_result, n_addr;

  entry_t q[$];           // reference model
  integer seed = 86;
  int errors, allocs, model_tail, exp_retired, exceptions, full_ignored;
  logic [31:0] last_count;
  logic frozen;           // fault in flight, hold dispatch

  ooo_writeback_top #(.NUM_LANES(NUM_LANES), .CB_DEPTH(CB_DEPTH)) i_dut (
    .CLK, .nRST, .alloc_valid, .alloc_rd, .alloc_index, .cb_full,
    .fu_valid, .fu_index, .fu_pc, .fu_result, .fu_addr,
    .fu_is_jump, .fu_is_load, .fu_is_store, .fu_illegal,
    .rf_wen, .rf_rd, .rf_wdata, .exc_valid, .exc_cause, .exc_pc, .retired_count
  );

  always #(CLK_NS/2) CLK = ~CLK;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_cause(input string name, input ooo_cb_pkg::cause_e got,
                             input ooo_cb_pkg::cause_e exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $unsigned($random(seed));
  endfunction

  // outputs of the last edge against the model head
  task automatic observe_retire();
    entry_t e;
    logic [31:0] delta;
    delta = retired_count - last_count;
    if (exc_valid) begin
      if (q.size() == 0 || !q[0].issued || !q[0].exc) begin
        $display("exception at %0t with no faulting entry at the head", $time);
        errors++;
      end else begin
        check_cause("exc_cause", exc_cause, q[0].cause);
        check_word("exc_pc", exc_pc, q[0].pc);
      end
      check_count("retired_count", retired_count, last_count);  // fault not counted
      foreach (q[i]) begin
        if (q[i].issued && !q[i].exc) exp_retired--;  // flushed younger results
      end
      q.delete();
      model_tail = 0;
      frozen = 1'b0;
      exceptions++;
    end else if (delta == 32'd1) begin
      if (q.size() == 0 || !q[0].issued || q[0].exc) begin
        $display("retirement at %0t does not match a completed head entry", $time);
        errors++;
      end else begin
        e = q.pop_front();
        check_word("rf_wen", word_t'(rf_wen), word_t'(e.rd != 5'd0));
        if (e.rd != 5'd0) begin
          check_word("rf_rd", word_t'(rf_rd), word_t'(e.rd));
          check_word("rf_wdata", rf_wdata, e.word);
        end
      end
    end else if (delta != 32'd0) begin
      $display("retired_count moved by more than one at %0t", $time);
      errors++;
    end else if (rf_wen) begin
      $display("rf_wen pulsed at %0t without a retirement", $time);
      errors++;
    end
    last_count = retired_count;
  endtask

  task automatic match_buffer_state();
    check_word("cb_full", word_t'(cb_full), word_t'(q.size() == CB_DEPTH));
    check_word("alloc_index", word_t'(alloc_index), word_t'(model_tail));
  endtask

  // alloc now applied is taken at the coming edge unless the model is full
  task automatic track_alloc();
    entry_t e;
    if (alloc_valid && q.size() == CB_DEPTH) full_ignored++;
    if (alloc_valid && q.size() < CB_DEPTH) begin
      e = '0;
      e.idx = IDX_W'(model_tail);
      e.rd  = alloc_rd;
      q.push_back(e);
      model_tail = (model_tail + 1) % CB_DEPTH;
      allocs++;
    end
  endtask

  // plays one functional unit result on lane l
  task automatic send_completion(input int l, input int qi);
    entry_t e;
    logic [31:0] r;
    logic [1:0] kind;  // 0 alu, 1 jump, 2 load, 3 store
    logic fault, ill;
    word_t result, addr;
    e = q[qi];
    r = rand32();
    kind   = r[1:0];
    fault  = (rand32() % 32'd20) == 32'd0;  // about 5%
    e.pc   = rand32() & ~32'h3;
    result = rand32();
    addr   = rand32();
    if (kind != 2'd0) addr[1:0] = 2'b00;  // alu ignores the address
    ill = 1'b0;
    if (fault) begin
      r = rand32();
      ill = (kind == 2'd0) || (r[3:2] == 2'd0);  // alu faults only as illegal
      addr[1:0] = (ill || r[1:0] != 2'b00) ? r[1:0] : 2'b10;
    end
    e.exc = ill || (kind != 2'd0 && addr[1:0] != 2'b00);
    if (ill)              e.cause = ooo_cb_pkg::ILLEGAL;
    else if (kind == 2'd1) e.cause = ooo_cb_pkg::MAL_INSN;
    else if (kind == 2'd2) e.cause = ooo_cb_pkg::MAL_LOAD;
    else                  e.cause = ooo_cb_pkg::MAL_STORE;
    e.word   = (kind == 2'd1) ? e.pc + 32'd4 : result;  // link value for jumps
    e.issued = 1'b1;
    q[qi] = e;
    if (e.exc) frozen = 1'b1;
    else       exp_retired++;
    n_valid[l]   = 1'b1;
    n_index[l]   = e.idx;
    n_pc[l]      = e.pc;
    n_result[l]  = result;
    n_addr[l]    = addr;
    n_jump[l]    = (kind == 2'd1);
    n_load[l]    = (kind == 2'd2);
    n_store[l]   = (kind == 2'd3);
    n_illegal[l] = ill;
  endtask

  task automatic choose_stimulus();
    int cands[$];
    int j;
    logic [31:0] r;
    n_valid = '0;
    n_index = '0;
    n_pc = '0;
    n_result = '0;
    n_addr = '0;
    {n_jump, n_load, n_store, n_illegal} = '0;
    // nothing younger than a fault already sent
    for (int i = 0; i < q.size(); i++) begin
      if (q[i].issued && q[i].exc) break;
      if (!q[i].issued) cands.push_back(i);
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      if (cands.size() != 0 && rand32() % 32'd100 < 32'd20) begin
        j = rand32() % cands.size();  // distinct slots per cycle
        send_completion(l, cands[j]);
        cands.delete(j);
      end
    end
    r = rand32();
    n_alloc = !frozen && allocs < NUM_OPS && (r % 32'd100 < 32'd75);
    n_rd    = (r[10:8] == 3'd0) ? 5'd0 : r[15:11];  // x0 now and then
  endtask

  task automatic apply_stimulus();
    alloc_valid <= n_alloc;
    alloc_rd    <= n_rd;
    fu_valid    <= n_valid;
    fu_index    <= n_index;
    fu_pc       <= n_pc;
    fu_result   <= n_result;
    fu_addr     <= n_addr;
    fu_is_jump  <= n_jump;
    fu_is_load  <= n_load;
    fu_is_store <= n_store;
    fu_illegal  <= n_illegal;
  endtask

  initial begin
    nRST <= 1'b0;
    {n_alloc, n_rd, n_valid, n_index, n_pc, n_result, n_addr} = '0;
    {n_jump, n_load, n_store, n_illegal} = '0;
    apply_stimulus();
    last_count = '0;
    frozen = 1'b0;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    while (allocs < NUM_OPS || q.size() != 0) begin
      @(negedge CLK);  // outputs settled
      observe_retire();
      match_buffer_state();
      track_alloc();
      choose_stimulus();
      @(posedge CLK);
      apply_stimulus();
    end
    repeat (2) @(negedge CLK);
    check_count("retired_count", retired_count, exp_retired);
    if (full_ignored == 0) begin
      $display("buffer never filled, alloc while full was not exercised");
      errors++;
    end
    $display("errors %0d, allocations %0d, retired %0d, exceptions %0d, full allocs %0d",
             errors, allocs, exp_retired, exceptions, full_ignored);
    if (errors == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, outstanding operations never retired", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- dv/ooo_writeback_properties.sv
// concurrent checks on the completion buffer and the retire unit
// one outcome per retirement, flush empties the buffer, occupancy bounds
// bound once into each module, ports of the other side tied off

`timescale 1ns/1ns

module ooo_writeback_properties #(
  parameter int CB_DEPTH = 8,
  parameter int IDX_W    = 3
) (
  input logic                CLK,
  input logic                nRST,
  input logic                flush,
  input logic                head_valid,
  input logic                rf_wen,
  input logic                exc_valid,
  input logic [IDX_W:0]      occupancy,
  input logic [CB_DEPTH-1:0] allocated,
  input logic                cb_full
);

  // a retirement is either a write or an exception
  a_single_outcome: assert property (@(posedge CLK) disable iff (!nRST)
    !(rf_wen && exc_valid))
    else $error("rf_wen and exc_valid high in the same cycle");

  // flush only from a completed head, nothing left at the head after it
  a_flush_head: assert property (@(posedge CLK) disable iff (!nRST)
    flush |-> head_valid ##1 !head_valid)
    else $error("flush without a valid head or buffer not cleared");

  // count bounded and equal to the allocated slots, full when all are taken
  a_occupancy: assert property (@(posedge CLK) disable iff (!nRST)
    (occupancy <= (IDX_W+1)'(CB_DEPTH)) &&
    (int'(occupancy) == $countones(allocated)) &&
    (cb_full == (&allocated)))
    else $error("occupancy %0d out of range or cb_full wrong", occupancy);

endmodule

bind retire_unit ooo_writeback_properties i_props_retire (
  .CLK, .nRST, .flush, .head_valid, .rf_wen, .exc_valid,
  .occupancy('0), .allocated('0), .cb_full(1'b0)   // no count in the retire unit
);

bind completion_buffer ooo_writeback_properties #(.CB_DEPTH(CB_DEPTH), .IDX_W(IDX_W))
  i_props_cb (
  .CLK, .nRST, .flush, .head_valid, .rf_wen(1'b0), .exc_valid(1'b0),
  .occupancy, .allocated, .cb_full
);

//--- design/ooo_writeback_top.sv
// completion side top level
// one completion buffer, NUM_LANES writeback lanes, the retire unit

`timescale 1ns/1ns

module ooo_writeback_top #(
  parameter  int NUM_LANES = 3,
  parameter  int CB_DEPTH  = 8,               // power of two
  localparam int IDX_W     = $clog2(CB_DEPTH)
) (
  input  logic                                          CLK,
  input  logic                                          nRST,
  // dispatch
  input  logic                                          alloc_valid,
  input  logic [4:0]                                    alloc_rd,
  output logic [IDX_W-1:0]                              alloc_index,
  output logic                                          cb_full,
  // functional unit results, one slice per lane
  input  logic [NUM_LANES-1:0]                          fu_valid,
  input  logic [NUM_LANES-1:0][IDX_W-1:0]               fu_index,
  input  logic [NUM_LANES-1:0][ooo_cb_pkg::XLEN-1:0]    fu_pc,
  input  logic [NUM_LANES-1:0][ooo_cb_pkg::XLEN-1:0]    fu_result,
  input  logic [NUM_LANES-1:0][ooo_cb_pkg::XLEN-1:0]    fu_addr,
  input  logic [NUM_LANES-1:0]                          fu_is_jump,
  input  logic [NUM_LANES-1:0]                          fu_is_load,
  input  logic [NUM_LANES-1:0]                          fu_is_store,
  input  logic [NUM_LANES-1:0]                          fu_illegal,
  // retire
  output logic                                          rf_wen,
  output logic [4:0]                                    rf_rd,
  output logic [ooo_cb_pkg::XLEN-1:0]                   rf_wdata,
  output logic                                          exc_valid,
  output ooo_cb_pkg::cause_e                            exc_cause,
  output logic [ooo_cb_pkg::XLEN-1:0]                   exc_pc,
  output logic [31:0]                                   retired_count
);

  // lanes to buffer
  logic [NUM_LANES-1:0]                 wb_valid;
  logic [NUM_LANES-1:0][IDX_W-1:0]      wb_index;
  logic [NUM_LANES-1:0]                 wb_exception;
  ooo_cb_pkg::cb_word_u [NUM_LANES-1:0] wb_word;
  // buffer to retire and back
  logic                                 head_valid;
  logic [4:0]                           head_rd;
  logic                                 head_exception;
  ooo_cb_pkg::cb_word_u                 head_word;
  logic                                 flush;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    fu_writeback_lane #(.IDX_W(IDX_W)) i_lane (
      .CLK, .nRST,
      .fu_valid(fu_valid[g]), .fu_index(fu_index[g]), .fu_pc(fu_pc[g]),
      .fu_result(fu_result[g]), .fu_addr(fu_addr[g]), .fu_is_jump(fu_is_jump[g]),
      .fu_is_load(fu_is_load[g]), .fu_is_store(fu_is_store[g]),
      .fu_illegal(fu_illegal[g]),
      .wb_valid(wb_valid[g]), .wb_index(wb_index[g]),
      .wb_exception(wb_exception[g]), .wb_word(wb_word[g])
    );
  end

  completion_buffer #(.CB_DEPTH(CB_DEPTH), .IDX_W(IDX_W), .NUM_LANES(NUM_LANES)) i_cb (
    .CLK, .nRST, .alloc_valid, .alloc_rd, .alloc_index, .cb_full,
    .wb_valid, .wb_index, .wb_exception, .wb_word,
    .flush, .head_valid, .head_rd, .head_exception, .head_word
  );

  retire_unit i_retire (
    .CLK, .nRST, .head_valid, .head_rd, .head_exception, .head_word,
    .flush, .rf_wen, .rf_rd, .rf_wdata, .exc_valid, .exc_cause, .exc_pc, .retired_count
  );

endmodule

//--- design/retire_unit.sv
// in-order retire of the completion buffer head
// register file write or precise exception with flush
// retired instruction counter

`timescale 1ns/1ns

module retire_unit (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          head_valid,
  input  logic [4:0]                    head_rd,
  input  logic                          head_exception,
  input  ooo_cb_pkg::cb_word_u          head_word,
  output logic                          flush,          // combinational
  output logic                          rf_wen,         // pulse
  output logic [4:0]                    rf_rd,
  output logic [ooo_cb_pkg::XLEN-1:0]   rf_wdata,
  output logic                          exc_valid,      // pulse
  output ooo_cb_pkg::cause_e            exc_cause,
  output logic [ooo_cb_pkg::XLEN-1:0]   exc_pc,
  output logic [31:0]                   retired_count
);

  logic retire_ok;   // normal retirement this cycle
  logic retire_exc;  // faulting head

  assign retire_ok  = head_valid & ~head_exception;
  assign retire_exc = head_valid &  head_exception;
  assign flush      = retire_exc;  // buffer clears at the next edge

  // strobes, pc and counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rf_wen        <= 1'b0;
      exc_valid     <= 1'b0;
      exc_pc        <= '0;
      retired_count <= '0;
    end else begin
      rf_wen    <= retire_ok & (head_rd != 5'd0);  // x0 never written
      exc_valid <= retire_exc;
      if (retire_ok)  retired_count <= retired_count + 32'd1;  // x0 ops counted too
      if (retire_exc) exc_pc <= {head_word.exc.pc_hi, 2'b00}; // back to byte address
    end
  end

  // write payload, qualified by rf_wen
  always_ff @(posedge CLK) begin
    if (retire_ok) begin
      rf_rd    <= head_rd;
      rf_wdata <= head_word.result;
    end
  end

  // cause payload, qualified by exc_valid
  always_ff @(posedge CLK) begin
    if (retire_exc) exc_cause <= head_word.exc.cause;
  end

endmodule

//--- design/completion_buffer.sv
// circular completion buffer
// in-order allocation at the tail, out-of-order marking from the lanes
// in-order head presented to the retire unit, full flush on exception

`timescale 1ns/1ns

module completion_buffer #(
  parameter int CB_DEPTH  = 8,
  parameter int IDX_W     = 3,
  parameter int NUM_LANES = 3
) (
  input  logic                                    CLK,
  input  logic                                    nRST,
  // dispatch side
  input  logic                                    alloc_valid,   // one-cycle strobe
  input  logic [4:0]                              alloc_rd,
  output logic [IDX_W-1:0]                        alloc_index,   // tail slot, every cycle
  output logic                                    cb_full,
  // lane writebacks
  input  logic [NUM_LANES-1:0]                    wb_valid,
  input  logic [NUM_LANES-1:0][IDX_W-1:0]         wb_index,
  input  logic [NUM_LANES-1:0]                    wb_exception,
  input  ooo_cb_pkg::cb_word_u [NUM_LANES-1:0]    wb_word,
  // retire side
  input  logic                                    flush,
  output logic                                    head_valid,
  output logic [4:0]                              head_rd,
  output logic                                    head_exception,
  output ooo_cb_pkg::cb_word_u                    head_word
);

  // control state per entry
  logic [CB_DEPTH-1:0]  allocated;
  logic [CB_DEPTH-1:0]  done;
  // payload per entry
  logic [CB_DEPTH-1:0]  exception;
  logic [4:0]           rd   [CB_DEPTH];
  ooo_cb_pkg::cb_word_u word [CB_DEPTH];

  logic [IDX_W-1:0]     head_ptr;
  logic [IDX_W-1:0]     tail_ptr;
  logic [IDX_W:0]       occupancy;   // 0 .. CB_DEPTH
  logic                 alloc_ok;
  logic                 pop;

  assign alloc_index = tail_ptr;
  assign cb_full     = (occupancy == (IDX_W+1)'(CB_DEPTH));

  // head straight from state
  assign head_valid     = allocated[head_ptr] & done[head_ptr];
  assign head_rd        = rd[head_ptr];
  assign head_exception = exception[head_ptr];
  assign head_word      = word[head_ptr];

  // dropped when full or flushing
  assign alloc_ok = alloc_valid & ~cb_full & ~flush;
  assign pop      = head_valid;  // retire never stalls

  // pointers and occupancy
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      occupancy <= '0;
    end else if (flush) begin
      head_ptr  <= '0;   // restart empty
      tail_ptr  <= '0;
      occupancy <= '0;
    end else begin
      if (alloc_ok) tail_ptr <= tail_ptr + 1'b1;  // wraps, depth is a power of two
      if (pop)      head_ptr <= head_ptr + 1'b1;
      case ({alloc_ok, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;          // both or neither
      endcase
    end
  end

  // allocated and done bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      allocated <= '0;
      done      <= '0;
    end else if (flush) begin
      allocated <= '0;  // popped faulting entry goes too
    end else begin
      if (pop) allocated[head_ptr] <= 1'b0;
      if (alloc_ok) begin
        allocated[tail_ptr] <= 1'b1;
        done[tail_ptr]      <= 1'b0;   // fresh slot, not yet completed
      end
      // all lanes land the same cycle, indices are distinct
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wb_valid[l]) done[wb_index[l]] <= 1'b1;
      end
    end
  end

  // payload, written without reset
  always_ff @(posedge CLK) begin
    if (alloc_ok) rd[tail_ptr] <= alloc_rd;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wb_valid[l]) begin
        exception[wb_index[l]] <= wb_exception[l];
        word[wb_index[l]]      <= wb_word[l];
      end
    end
  end

endmodule

//--- design/fu_writeback_lane.sv
// writeback lane for one functional unit
// checks the result for faults, forms the buffer word
// registers it for one cycle toward the completion buffer

`timescale 1ns/1ns

module fu_writeback_lane #(
  parameter int IDX_W = 3
) (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              fu_valid,     // result strobe
  input  logic [IDX_W-1:0]                  fu_index,     // buffer slot of this op
  input  logic [ooo_cb_pkg::XLEN-1:0]       fu_pc,
  input  logic [ooo_cb_pkg::XLEN-1:0]       fu_result,
  input  logic [ooo_cb_pkg::XLEN-1:0]       fu_addr,      // jump target or mem address
  input  logic                              fu_is_jump,
  input  logic                              fu_is_load,
  input  logic                              fu_is_store,
  input  logic                              fu_illegal,
  output logic                              wb_valid,
  output logic [IDX_W-1:0]                  wb_index,
  output logic                              wb_exception,
  output ooo_cb_pkg::cb_word_u              wb_word
);

  logic               addr_mis;   // low two address bits set
  logic               mis_jump;
  logic               mis_load;
  logic               mis_store;
  logic               fault;
  ooo_cb_pkg::cause_e cause;
  ooo_cb_pkg::cb_word_u word;     // word before the register

  assign addr_mis  = (fu_addr[1:0] != 2'b00);
  assign mis_jump  = fu_is_jump  & addr_mis;
  assign mis_load  = fu_is_load  & addr_mis;
  assign mis_store = fu_is_store & addr_mis;
  assign fault     = fu_illegal | mis_jump | mis_load | mis_store;

  // priority order, illegal wins over any misalignment
  always_comb begin
    if (fu_illegal)    cause = ooo_cb_pkg::ILLEGAL;
    else if (mis_jump) cause = ooo_cb_pkg::MAL_INSN;
    else if (mis_load) cause = ooo_cb_pkg::MAL_LOAD;
    else               cause = ooo_cb_pkg::MAL_STORE;
  end

  always_comb begin
    word = '0;
    if (fault) begin
      word.exc.cause = cause;
      word.exc.pc_hi = fu_pc[31:2];  // record holds word address of the pc
    end else if (fu_is_jump) begin
      word.result = fu_pc + 32'd4;   // link value
    end else begin
      word.result = fu_result;
    end
  end

  // strobe, reset cleared
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) wb_valid <= 1'b0;
    else       wb_valid <= fu_valid;
  end

  // payload, only qualified by wb_valid
  always_ff @(posedge CLK) begin
    if (fu_valid) begin
      wb_index     <= fu_index;
      wb_exception <= fault;
      wb_word      <= word;
    end
  end

endmodule

//--- design/ooo_cb_pkg.sv
// shared types for the completion side of the ooo core
// exception cause codes, exception record, buffer word union
// data and address width

package ooo_cb_pkg;

  // machine word and address width
  localparam int XLEN = 32;

  // exception causes, fixed 2-bit encoding
  typedef enum logic [1:0] {
    MAL_INSN  = 2'd0,  // jump target not word aligned
    MAL_LOAD  = 2'd1,  // load word address misaligned
    MAL_STORE = 2'd2,  // store word address misaligned
    ILLEGAL   = 2'd3   // illegal instruction flag from the fu
  } cause_e;

  // exception record, fills one buffer word
  // pc low two bits always zero for a legal fetch, so dropped
  typedef struct packed {
    cause_e      cause;  // [31:30]
    logic [29:0] pc_hi;  // faulting pc[31:2]
  } exc_rec_t;

  // one buffer word, two readings
  // entry exception bit picks which one is live
  typedef union packed {
    logic [XLEN-1:0] result;  // register write value
    exc_rec_t        exc;     // exception record
  } cb_word_u;

  // exc_rec_t must fill the word exactly for the union
  // 2 bits of cause plus 30 bits of pc
  // result, link value or record share the same storage

endpackage
